//--- hdl/sa_pkg.sv
`default_nettype none

package sa_pkg;

  //////////////////////////////////////////////////
  // element types
  //////////////////////////////////////////////////

  // activations and weights
  typedef logic signed [15:0] act_t;

  // partial sums, no saturation
  typedef logic signed [31:0] acc_t;

  //////////////////////////////////////////////////
  // row buffer ownership
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    grant_none  = 2'd0,
    grant_host  = 2'd1,
    grant_fetch = 2'd2
  } grant_e;

  // rising: lane k delayed by k
  // falling: lane k delayed by WIDTH-1-k
  typedef enum logic {
    skew_rising  = 1'b0,
    skew_falling = 1'b1
  } lane_dir_e;

endpackage

`default_nettype wire

//--- hdl/row_buffer_ram.sv
`timescale 1ns/1ns
`default_nettype none

module row_buffer_ram import sa_pkg::*; #(
  parameter int DIM       = 4,
  parameter int ROW_DEPTH = 16
) (
  input  wire logic                         clk,
  input  wire logic                         ram_en,
  input  wire logic                         ram_we,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] ram_addr,
  input  wire act_t [DIM-1:0]               ram_wdata,
  output      act_t [DIM-1:0]               ram_rdata
);

  // one activation row per entry, lane 0 in the low bits
  act_t [DIM-1:0] mem [ROW_DEPTH];

  // write at the edge
  // read registered, held until the next read
  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end else begin
        ram_rdata <= mem[ram_addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/row_buffer_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module row_buffer_arbiter import sa_pkg::*; #(
  parameter int DIM       = 4,
  parameter int ROW_DEPTH = 16
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  // host write side
  input  wire logic                         host_req,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] host_addr,
  input  wire act_t [DIM-1:0]               host_wdata,
  output      logic                         host_ack,
  // fetcher read side
  input  wire logic                         fetch_req,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] fetch_addr,
  output      logic                         fetch_ack,
  output      act_t [DIM-1:0]               fetch_rdata,
  // memory side
  output      logic                         ram_en,
  output      logic                         ram_we,
  output      logic [$clog2(ROW_DEPTH)-1:0] ram_addr,
  output      act_t [DIM-1:0]               ram_wdata,
  input  wire act_t [DIM-1:0]               ram_rdata
);

  typedef enum logic [1:0] {st_idle, st_access, st_hold} state_e;

  state_e         state;
  grant_e         owner;
  grant_e         winner;
  logic           last_host;
  logic           owner_req;
  act_t [DIM-1:0] rdata_q;

  //////////////////////////////////////////////////
  // round robin pick, only from idle
  //////////////////////////////////////////////////

  always_comb begin
    winner = grant_none;
    if (state == st_idle) begin
      // tie goes to whoever lost last time
      if (host_req && fetch_req) begin
        winner = last_host ? grant_fetch : grant_host;
      end else if (host_req) begin
        winner = grant_host;
      end else if (fetch_req) begin
        winner = grant_fetch;
      end
    end
  end

  // access issued in the grant cycle itself
  assign ram_en    = (winner != grant_none);
  assign ram_we    = (winner == grant_host);
  assign ram_addr  = (winner == grant_host) ? host_addr : fetch_addr;
  assign ram_wdata = host_wdata;

  assign owner_req   = (owner == grant_host) ? host_req : fetch_req;
  assign fetch_rdata = rdata_q;

  //////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      owner     <= grant_none;
      last_host <= 1'b1;
      host_ack  <= 1'b0;
      fetch_ack <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (winner != grant_none) begin
            owner     <= winner;
            last_host <= (winner == grant_host);
            state     <= st_access;
          end
        end
        // ram output valid now, ack goes up with the data
        st_access: begin
          host_ack  <= (owner == grant_host);
          fetch_ack <= (owner == grant_fetch);
          state     <= st_hold;
        end
        // owner keeps the buffer until its req drops
        st_hold: begin
          if (!owner_req) begin
            host_ack  <= 1'b0;
            fetch_ack <= 1'b0;
            owner     <= grant_none;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // read data held for the whole ack phase
  always_ff @(posedge clk) begin
    if (state == st_access && owner == grant_fetch) begin
      rdata_q <= ram_rdata;
    end
  end

  // ack outlives its req by one cycle at most
  a_host_ack_follows: assert property (@(posedge clk) disable iff (reset)
    host_ack && !host_req |=> !host_ack);
  a_fetch_ack_follows: assert property (@(posedge clk) disable iff (reset)
    fetch_ack && !fetch_req |=> !fetch_ack);
  a_one_ack: assert property (@(posedge clk) disable iff (reset)
    !(host_ack && fetch_ack));

endmodule

`default_nettype wire

//--- hdl/row_fetcher.sv
`timescale 1ns/1ns
`default_nettype none

module row_fetcher import sa_pkg::*; #(
  parameter int DIM       = 4,
  parameter int ROW_DEPTH = 16
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         start,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] row_base,
  input  wire logic [$clog2(ROW_DEPTH):0]   row_count,
  output      logic                         fetch_req,
  output      logic [$clog2(ROW_DEPTH)-1:0] fetch_addr,
  input  wire logic                         fetch_ack,
  input  wire act_t [DIM-1:0]               fetch_rdata,
  output      logic                         row_valid,
  output      act_t [DIM-1:0]               row_data,
  output      logic                         busy
);

  localparam int AW = $clog2(ROW_DEPTH);

  typedef enum logic [1:0] {st_idle, st_req, st_drop} state_e;

  state_e         state;
  logic [AW-1:0]  addr_q;
  logic [AW:0]    left_q;
  act_t [DIM-1:0] row_q;

  assign fetch_req  = (state == st_req);
  assign fetch_addr = addr_q;
  assign row_data   = row_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      addr_q    <= '0;
      left_q    <= '0;
      busy      <= 1'b0;
      row_valid <= 1'b0;
    end else begin
      row_valid <= 1'b0;
      case (state)
        // start only sampled here, so a start while busy is dropped
        st_idle: begin
          if (start && row_count != '0) begin
            addr_q <= row_base;
            left_q <= row_count;
            busy   <= 1'b1;
            state  <= st_req;
          end
        end
        st_req: begin
          if (fetch_ack) begin
            state <= st_drop;
          end
        end
        // req low, wait for ack to fall, then issue the row
        st_drop: begin
          if (!fetch_ack) begin
            row_valid <= 1'b1;
            addr_q    <= addr_q + 1'b1;
            left_q    <= left_q - 1'b1;
            if (left_q == 1) begin
              busy  <= 1'b0;
              state <= st_idle;
            end else begin
              state <= st_req;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // row word captured while ack is up
  always_ff @(posedge clk) begin
    if (state == st_req && fetch_ack) begin
      row_q <= fetch_rdata;
    end
  end

  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    fetch_req && $past(fetch_req) |-> $stable(fetch_addr));

endmodule

`default_nettype wire

//--- hdl/lane_skew.sv
`timescale 1ns/1ns
`default_nettype none

module lane_skew import sa_pkg::*; #(
  parameter int        WIDTH  = 4,
  parameter type       elem_t = act_t,
  parameter lane_dir_e DIR    = skew_rising
) (
  input  wire logic              clk,
  input  wire elem_t [WIDTH-1:0] lanes_in,
  output      elem_t [WIDTH-1:0] lanes_out
);

  //////////////////////////////////////////////////
  // one delay chain per lane
  //////////////////////////////////////////////////

  for (genvar k = 0; k < WIDTH; k++) begin : g_lane
    // chain length from lane index and direction
    localparam int DLY = (DIR == skew_rising) ? k : (WIDTH - 1 - k);

    if (DLY == 0) begin : g_wire
      // zero delay lane, straight through
      assign lanes_out[k] = lanes_in[k];
    end else begin : g_chain
      elem_t chain [DLY];

      // no reset, valid travels on its own path
      always_ff @(posedge clk) begin
        chain[0] <= lanes_in[k];
        for (int n = 1; n < DLY; n++) begin
          chain[n] <= chain[n-1];
        end
      end

      assign lanes_out[k] = chain[DLY-1];
    end
  end

endmodule

`default_nettype wire

//--- hdl/mac_array.sv
`timescale 1ns/1ns
`default_nettype none

module mac_array import sa_pkg::*; #(
  parameter int DIM = 4
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         weight_load,
  input  wire logic [$clog2(DIM*DIM)-1:0]   weight_index,
  input  wire act_t                         weight_data,
  input  wire act_t [DIM-1:0]               act_in,
  output      acc_t [DIM-1:0]               psum_out
);

  localparam int WI_W = $clog2(DIM*DIM);

  // act_w[i][j] is the activation entering cell (i,j) from the left
  act_t act_w [DIM][DIM];
  // psum_w[i][j] is the partial sum entering cell (i,j) from above
  acc_t psum_w [DIM+1][DIM];

  //////////////////////////////////////////////////
  // array edges
  //////////////////////////////////////////////////

  for (genvar i = 0; i < DIM; i++) begin : g_left
    // lane i already skewed by i cycles
    assign act_w[i][0] = act_in[i];
  end

  for (genvar j = 0; j < DIM; j++) begin : g_edge
    // top row starts from zero
    assign psum_w[0][j] = '0;
    // bottom row leaves skewed by column
    assign psum_out[j]  = psum_w[DIM][j];
  end

  //////////////////////////////////////////////////
  // cell grid
  //////////////////////////////////////////////////

  for (genvar i = 0; i < DIM; i++) begin : g_row
    for (genvar j = 0; j < DIM; j++) begin : g_col
      act_t w_q;
      acc_t psum_q;

      // stationary weight, index is row*DIM + col
      always_ff @(posedge clk) begin
        if (reset) begin
          w_q <= '0;
        end else if (weight_load && weight_index == WI_W'(i * DIM + j)) begin
          w_q <= weight_data;
        end
      end

      // sum from above plus own product, passed down
      always_ff @(posedge clk) begin
        if (reset) begin
          psum_q <= '0;
        end else begin
          psum_q <= psum_w[i][j] + acc_t'(act_w[i][j]) * acc_t'(w_q);
        end
      end

      assign psum_w[i+1][j] = psum_q;

      // activation pass to the right, none out of the last column
      if (j < DIM - 1) begin : g_pass
        act_t act_q;

        always_ff @(posedge clk) begin
          if (reset) begin
            act_q <= '0;
          end else begin
            act_q <= act_w[i][j];
          end
        end

        assign act_w[i][j+1] = act_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/sa_top.sv
`timescale 1ns/1ns
`default_nettype none

module sa_top import sa_pkg::*; #(
  parameter int DIM       = 4,
  parameter int ROW_DEPTH = 16
) (
  input  wire logic                         clk,
  input  wire logic                         reset,
  // row buffer writes
  input  wire logic                         host_req,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] host_addr,
  input  wire act_t [DIM-1:0]               host_wdata,
  output      logic                         host_ack,
  // weight load
  input  wire logic                         weight_load,
  input  wire logic [$clog2(DIM*DIM)-1:0]   weight_index,
  input  wire act_t                         weight_data,
  // run control
  input  wire logic                         start,
  input  wire logic [$clog2(ROW_DEPTH)-1:0] row_base,
  input  wire logic [$clog2(ROW_DEPTH):0]   row_count,
  output      logic                         busy,
  output      logic                         done,
  // results, no back-pressure
  output      logic                         result_valid,
  output      acc_t [DIM-1:0]               result_row
);

  localparam int AW  = $clog2(ROW_DEPTH);
  localparam int LAT = 2 * DIM - 1;

  logic           ram_en, ram_we;
  logic [AW-1:0]  ram_addr;
  act_t [DIM-1:0] ram_wdata, ram_rdata;
  logic           fetch_req, fetch_ack;
  logic [AW-1:0]  fetch_addr;
  act_t [DIM-1:0] fetch_rdata;
  logic           row_valid;
  act_t [DIM-1:0] row_data, act_skewed;
  acc_t [DIM-1:0] psum_skewed;
  logic [LAT-1:0] vld_pipe;
  logic           run_pending;

  row_buffer_ram #(.DIM(DIM), .ROW_DEPTH(ROW_DEPTH)) ram_i (
    .clk, .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  row_buffer_arbiter #(.DIM(DIM), .ROW_DEPTH(ROW_DEPTH)) arbiter_i (
    .clk, .reset,
    .host_req, .host_addr, .host_wdata, .host_ack,
    .fetch_req, .fetch_addr, .fetch_ack, .fetch_rdata,
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  row_fetcher #(.DIM(DIM), .ROW_DEPTH(ROW_DEPTH)) fetcher_i (
    .clk, .reset, .start, .row_base, .row_count,
    .fetch_req, .fetch_addr, .fetch_ack, .fetch_rdata,
    .row_valid, .row_data, .busy
  );

  lane_skew #(.WIDTH(DIM), .elem_t(act_t), .DIR(skew_rising)) input_skew (
    .clk, .lanes_in(row_data), .lanes_out(act_skewed)
  );

  mac_array #(.DIM(DIM)) array_i (
    .clk, .reset, .weight_load, .weight_index, .weight_data,
    .act_in(act_skewed), .psum_out(psum_skewed)
  );

  // column j leaves at DIM+j, deskew tops it up to 2*DIM-1
  lane_skew #(.WIDTH(DIM), .elem_t(acc_t), .DIR(skew_falling)) output_deskew (
    .clk, .lanes_in(psum_skewed), .lanes_out(result_row)
  );

  //////////////////////////////////////////////////
  // valid tracking and run completion
  //////////////////////////////////////////////////

  assign result_valid = vld_pipe[LAT-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe    <= '0;
      run_pending <= 1'b0;
      done        <= 1'b0;
    end else begin
      // one stage per cycle of array latency
      vld_pipe <= {vld_pipe[LAT-2:0], row_valid};
      done     <= 1'b0;
      if (busy) begin
        run_pending <= 1'b1;
      end else if (run_pending && !row_valid && vld_pipe == '0) begin
        // fetcher finished and last beat gone
        run_pending <= 1'b0;
        done        <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_sa_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sa_top import sa_pkg::*; ();

  localparam int DIM        = 4;
  localparam int ROW_DEPTH  = 16;
  // 6 identity + 8 random + 6 contention + 6 readback
  localparam int TOTAL_ROWS = 26;
  localparam int TIMEOUT    = 200 * TOTAL_ROWS + 1000;

  typedef act_t [DIM-1:0] act_row_t;
  typedef acc_t [DIM-1:0] acc_row_t;

  logic        clk = 1'b0;
  logic        reset, host_req, weight_load, start;
  logic [3:0]  host_addr, weight_index, row_base;
  logic [4:0]  row_count;
  act_row_t    host_wdata;
  act_t        weight_data;
  logic        host_ack, busy, done, result_valid;
  acc_row_t    result_row;

  // testbench copies of buffer and weights
  act_row_t    row_model [ROW_DEPTH];
  act_t        w_model [DIM][DIM];
  acc_row_t    exp_q [$];
  logic [31:0] lcg_state = 32'h9da7;
  int          mismatch_count = 0, fail_count = 0;
  int          beats = 0, done_seen = 0, host_writes = 0, host_acks = 0;
  logic        host_ack_prev = 1'b0;

  sa_top #(.DIM(DIM), .ROW_DEPTH(ROW_DEPTH)) dut_i (
    .clk, .reset, .host_req, .host_addr, .host_wdata, .host_ack,
    .weight_load, .weight_index, .weight_data,
    .start, .row_base, .row_count, .busy, .done, .result_valid, .result_row
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // random data and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic act_row_t random_row();
    act_row_t    r;
    logic [31:0] v;
    for (int k = 0; k < DIM; k++) begin
      v    = lcg_next();
      // upper half has the better randomness
      r[k] = act_t'(v[31:16]);
    end
    return r;
  endfunction

  // element j = sum over i of row[i] * w(i,j), wrapping in acc_t
  function automatic acc_row_t expected_result(act_row_t row);
    acc_row_t r;
    for (int j = 0; j < DIM; j++) begin
      r[j] = '0;
      for (int i = 0; i < DIM; i++) begin
        r[j] = r[j] + acc_t'(row[i]) * acc_t'(w_model[i][j]);
      end
    end
    return r;
  endfunction

  task automatic compare_acc(string name, acc_t got, acc_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_count(string name, int got, int exp);
    if (got != exp) begin
      mismatch_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // host side drivers
  //////////////////////////////////////////////////

  // four-phase write, ack must drop soon after req
  task automatic host_write(logic [3:0] addr, act_row_t data);
    int wait_cycles;
    @(posedge clk);
    host_req   <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    host_writes++;
    do @(posedge clk); while (!host_ack);
    host_req       <= 1'b0;
    row_model[addr] = data;
    wait_cycles     = 0;
    do begin
      @(posedge clk);
      wait_cycles++;
    end while (host_ack);
    if (wait_cycles > 2) begin
      fail_count++;
      $display("host_ack stayed high %0d cycles after host_req fell", wait_cycles);
    end
  endtask

  task automatic load_weights(bit identity);
    logic [31:0] v;
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        if (identity) begin
          w_model[i][j] = act_t'(i == j);
        end else begin
          v             = lcg_next();
          w_model[i][j] = act_t'(v[31:16]);
        end
        @(posedge clk);
        weight_load  <= 1'b1;
        weight_index <= 4'(i * DIM + j);
        weight_data  <= w_model[i][j];
      end
    end
    @(posedge clk);
    weight_load <= 1'b0;
  endtask

  // queue expected rows, start, wait for done, check beats and done pulses
  task automatic run_rows(logic [3:0] base, logic [4:0] count, bit poke);
    int beats_before, done_before;
    for (int r = 0; r < count; r++) begin
      exp_q.push_back(expected_result(row_model[base + r]));
    end
    beats_before = beats;
    done_before  = done_seen;
    @(posedge clk);
    start     <= 1'b1;
    row_base  <= base;
    row_count <= count;
    @(posedge clk);
    start <= 1'b0;
    // fetcher took the start at this edge
    @(negedge clk);
    compare_bit("busy after start", busy, 1'b1);
    if (poke) begin
      // second start mid-run, must add no rows
      repeat (3) @(posedge clk);
      start     <= 1'b1;
      row_base  <= 4'd0;
      row_count <= 5'd3;
      @(posedge clk);
      start <= 1'b0;
    end
    do @(posedge clk); while (!done);
    // all rows issued long before the last result
    compare_bit("busy at done", busy, 1'b0);
    repeat (5) @(posedge clk);
    compare_count("result beats", beats - beats_before, int'(count));
    compare_count("done pulses", done_seen - done_before, 1);
  endtask

  //////////////////////////////////////////////////
  // result checker, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    acc_row_t exp_row;
    if (!reset && result_valid) begin
      beats++;
      if (exp_q.size() == 0) begin
        fail_count++;
        $display("result beat arrived with no row expected");
      end else begin
        exp_row = exp_q.pop_front();
        for (int j = 0; j < DIM; j++) begin
          compare_acc($sformatf("result_row[%0d]", j), result_row[j], exp_row[j]);
        end
      end
    end
    if (!reset && done) begin
      done_seen++;
    end
    // one rising ack per host write
    if (!reset && host_ack && !host_ack_prev) begin
      host_acks++;
    end
    host_ack_prev = host_ack;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT) @(posedge clk);
    $display("timeout after %0d cycles, run did not finish", TIMEOUT);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    host_req     = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    weight_load  = 1'b0;
    weight_index = '0;
    weight_data  = '0;
    start        = 1'b0;
    row_base     = '0;
    row_count    = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // identity weights, rows come back sign extended
    for (int a = 0; a < 6; a++) begin
      host_write(4'(a), random_row());
    end
    load_weights(1'b1);
    run_rows(4'd0, 5'd6, 1'b0);
    // random weights and rows, extra start while busy
    for (int a = 6; a < 14; a++) begin
      host_write(4'(a), random_row());
    end
    load_weights(1'b0);
    run_rows(4'd6, 5'd8, 1'b1);
    // host writes rows 10..15 while the fetcher reads 0..5
    fork
      run_rows(4'd0, 5'd6, 1'b0);
      for (int a = 10; a < 16; a++) begin
        host_write(4'(a), random_row());
      end
    join
    // read back what was written under contention
    run_rows(4'd10, 5'd6, 1'b0);
    compare_count("host acks", host_acks, host_writes);
    if (exp_q.size() != 0) begin
      fail_count++;
      $display("%0d expected rows never arrived", exp_q.size());
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hdl/sa_pkg.sv
hdl/row_buffer_ram.sv
hdl/row_buffer_arbiter.sv
hdl/row_fetcher.sv
hdl/lane_skew.sv
hdl/mac_array.sv
hdl/sa_top.sv
sim/tb_sa_top.sv

//--- Makefile
# Verilator build and run of the systolic array testbench

TOP := tb_sa_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
